// ==== hdl/icache_ctrl.sv ====
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
(
    input  wire logic                            clk,
    input  wire logic                            rstn,
    // pipeline side
    input  wire logic                            i_req_valid,
    input  wire fetch_req_t                      i_req,
    output logic                                 o_req_ready,
    output logic                                 o_resp_valid,
    output fetch_resp_t                          o_resp,
    // way storage
    output logic [INDEX_W-1:0]                   o_rd_index,
    output logic [INDEX_W-1:0]                   o_wr_index,
    output logic [WAY_NUM-1:0]                   o_way_we,
    output logic [TAG_W-1:0]                     o_wr_tag,
    input  wire tagv_t [WAY_NUM-1:0]             i_way_tagv,
    input  wire logic [WAY_NUM-1:0][LINE_W-1:0]  i_way_line,
    // refill unit
    output logic                                 o_fill_start,
    output logic [31:0]                          o_fill_addr,
    input  wire logic                            i_fill_done,
    input  wire logic [LINE_W-1:0]               i_fill_line
);

    cache_state_t state, next_state;

    fetch_req_t         req_buf;    // request under lookup or refill
    logic               accept;

    logic [INDEX_W-1:0] req_index;
    logic [TAG_W-1:0]   req_tag;
    logic [2:0]         req_word;   // which 64-bit pair in the line
    logic               fault;

    logic [WAY_NUM-1:0] hit;
    logic               cache_hit;
    logic               hit_way;

    logic [SET_NUM-1:0] lru;        // per set: way to replace next
    logic               victim;

    logic [LINE_W-1:0]  sel_line;
    logic [FETCH_W-1:0] sel_pair;

    // request buffer fields
    assign req_index = req_buf.addr[OFFSET_W +: INDEX_W];
    assign req_tag   = req_buf.addr[OFFSET_W + INDEX_W +: TAG_W];
    assign req_word  = req_buf.addr[OFFSET_W-1:3];
    assign fault     = (req_buf.addr[1:0] != 2'b00);

    // tag compare on the registered way outputs
    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            hit[w] = i_way_tagv[w].valid && (i_way_tagv[w].tag == req_tag);
        end
    end

    assign cache_hit = |hit;
    assign hit_way   = hit[1];      // only meaningful with cache_hit
    assign victim    = lru[req_index];

    // handshake with the pipeline
    always_comb begin
        unique case (state)
            IDLE:    o_req_ready = 1'b1;
            LOOKUP:  o_req_ready = fault || cache_hit;
            MISS:    o_req_ready = 1'b0;
            REFILL:  o_req_ready = 1'b1;
            default: o_req_ready = 1'b0;
        endcase
    end

    assign accept = i_req_valid && o_req_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_buf <= i_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (accept) next_state = LOOKUP;
            end
            LOOKUP: begin
                if (fault || cache_hit) begin
                    next_state = accept ? LOOKUP : IDLE;
                end else begin
                    next_state = MISS;
                end
            end
            MISS: begin
                if (i_fill_done) next_state = REFILL;   // mem stall just stretches this
            end
            REFILL: begin
                next_state = accept ? LOOKUP : IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // miss request, issued once on leaving LOOKUP
    assign o_fill_start = (state == LOOKUP) && !fault && !cache_hit;
    assign o_fill_addr  = {req_buf.addr[31:OFFSET_W], {OFFSET_W{1'b0}}};

    // ram read index comes straight from the incoming request
    assign o_rd_index = i_req.addr[OFFSET_W +: INDEX_W];
    assign o_wr_index = req_index;
    assign o_wr_tag   = req_tag;

    always_comb begin
        o_way_we = '0;
        if (state == REFILL) begin
            o_way_we[victim] = 1'b1;
        end
    end

    // lru update: the way just used is kept, the other one goes next
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (state == LOOKUP && !fault && cache_hit) begin
            lru[req_index] <= ~hit_way;
        end else if (state == REFILL) begin
            lru[req_index] <= ~victim;
        end
    end

    // word select from the hit way or the refill buffer
    assign sel_line = (state == REFILL) ? i_fill_line : i_way_line[hit_way];
    assign sel_pair = sel_line[req_word * FETCH_W +: FETCH_W];

    assign o_resp_valid = ((state == LOOKUP) && (fault || cache_hit)) || (state == REFILL);

    always_comb begin
        o_resp.pc = req_buf.addr;
        if (fault) begin
            o_resp.data = {INST_NOP, INST_NOP};
            o_resp.exc  = EXC_ADEF;
        end else begin
            o_resp.data = sel_pair;
            o_resp.exc  = EXC_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int INDEX_W  = 6;    // 64 sets
    localparam int OFFSET_W = 6;    // 64-byte lines
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;
    localparam int SET_NUM  = 1 << INDEX_W;
    localparam int LINE_W   = (1 << OFFSET_W) * 8;
    localparam int FETCH_W  = 64;   // two instructions per fetch
    localparam int WAY_NUM  = 2;

    // andi r0, r0, 0
    localparam logic [31:0] INST_NOP = 32'h0340_0000;

    // controller states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LOOKUP = 2'd1,
        MISS   = 2'd2,
        REFILL = 2'd3
    } cache_state_t;

    // exception code returned with a fetch
    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_ADEF = 7'h08    // fetch address not word aligned
    } exc_t;

    // pipeline request
    typedef struct packed {
        logic [31:0] addr;
    } fetch_req_t;

    // response to the pipeline
    typedef struct packed {
        logic [31:0]        pc;
        logic [FETCH_W-1:0] data;
        exc_t               exc;
    } fetch_resp_t;

    // one tag entry of a way
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tagv_t;

endpackage

`default_nettype wire

// ==== hdl/icache_refill.sv ====
`default_nettype none

module icache_refill
    import icache_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rstn,
    // from the controller
    input  wire logic              i_fill_start,
    input  wire logic [31:0]       i_fill_addr,
    // memory side
    output logic                   o_mem_valid,
    output logic [31:0]            o_mem_addr,
    input  wire logic              i_mem_ready,
    input  wire logic [LINE_W-1:0] i_mem_line,
    // back to the controller
    output logic                   o_fill_done,
    output logic [LINE_W-1:0]      o_fill_line
);

    logic              mem_fire;
    logic [LINE_W-1:0] ret_buf;     // return buffer

    assign mem_fire = o_mem_valid && i_mem_ready;

    // request stays up until memory takes it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_mem_valid <= 1'b0;
        end else if (i_fill_start) begin
            o_mem_valid <= 1'b1;
        end else if (mem_fire) begin
            o_mem_valid <= 1'b0;
        end
    end

    // line address held while the request is pending
    always_ff @(posedge clk) begin
        if (i_fill_start) begin
            o_mem_addr <= {i_fill_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
        end
    end

    // line arrives with ready
    always_ff @(posedge clk) begin
        if (mem_fire) begin
            ret_buf <= i_mem_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_fill_done <= 1'b0;
        end else begin
            o_fill_done <= mem_fire;    // one cycle after ready
        end
    end

    assign o_fill_line = ret_buf;   // stable until the next miss returns

endmodule

`default_nettype wire

// ==== hdl/icache_top.sv ====
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rstn,
    // fetch unit
    input  wire logic              i_req_valid,
    input  wire fetch_req_t        i_req,
    output logic                   o_req_ready,
    output logic                   o_resp_valid,
    output fetch_resp_t            o_resp,
    // memory
    output logic                   o_mem_valid,
    output logic [31:0]            o_mem_addr,
    input  wire logic              i_mem_ready,
    input  wire logic [LINE_W-1:0] i_mem_line
);

    logic [INDEX_W-1:0]              rd_index;
    logic [INDEX_W-1:0]              wr_index;
    logic [WAY_NUM-1:0]              way_we;
    logic [TAG_W-1:0]                wr_tag;
    tagv_t [WAY_NUM-1:0]             way_tagv;
    logic [WAY_NUM-1:0][LINE_W-1:0]  way_line;

    logic                            fill_start;
    logic [31:0]                     fill_addr;
    logic                            fill_done;
    logic [LINE_W-1:0]               fill_line;    // also the write data of both ways

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .o_req_ready  (o_req_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp       (o_resp),
        .o_rd_index   (rd_index),
        .o_wr_index   (wr_index),
        .o_way_we     (way_we),
        .o_wr_tag     (wr_tag),
        .i_way_tagv   (way_tagv),
        .i_way_line   (way_line),
        .o_fill_start (fill_start),
        .o_fill_addr  (fill_addr),
        .i_fill_done  (fill_done),
        .i_fill_line  (fill_line)
    );

    icache_way u_way0 (
        .clk        (clk),
        .rstn       (rstn),
        .i_rd_index (rd_index),
        .i_wr_index (wr_index),
        .i_we       (way_we[0]),
        .i_wr_tag   (wr_tag),
        .i_wr_line  (fill_line),
        .o_tagv     (way_tagv[0]),
        .o_line     (way_line[0])
    );

    icache_way u_way1 (
        .clk        (clk),
        .rstn       (rstn),
        .i_rd_index (rd_index),
        .i_wr_index (wr_index),
        .i_we       (way_we[1]),
        .i_wr_tag   (wr_tag),
        .i_wr_line  (fill_line),
        .o_tagv     (way_tagv[1]),
        .o_line     (way_line[1])
    );

    icache_refill u_refill (
        .clk          (clk),
        .rstn         (rstn),
        .i_fill_start (fill_start),
        .i_fill_addr  (fill_addr),
        .o_mem_valid  (o_mem_valid),
        .o_mem_addr   (o_mem_addr),
        .i_mem_ready  (i_mem_ready),
        .i_mem_line   (i_mem_line),
        .o_fill_done  (fill_done),
        .o_fill_line  (fill_line)
    );

endmodule

`default_nettype wire

// ==== hdl/icache_way.sv ====
`default_nettype none

module icache_way
    import icache_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rstn,
    input  wire logic [INDEX_W-1:0] i_rd_index,
    input  wire logic [INDEX_W-1:0] i_wr_index,
    input  wire logic               i_we,
    input  wire logic [TAG_W-1:0]   i_wr_tag,
    input  wire logic [LINE_W-1:0]  i_wr_line,
    output tagv_t                   o_tagv,
    output logic [LINE_W-1:0]       o_line
);

    logic [TAG_W-1:0]   tag_mem  [SET_NUM];
    logic [LINE_W-1:0]  line_mem [SET_NUM];
    logic [SET_NUM-1:0] valid_q;            // cleared on reset, unlike the arrays

    logic               rd_valid_q;
    logic [TAG_W-1:0]   rd_tag_q;
    logic               bypass;

    // a read of the set being refilled sees the new line
    assign bypass = i_we && (i_rd_index == i_wr_index);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (i_we) begin
            valid_q[i_wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= bypass | valid_q[i_rd_index];
        end
    end

    // tag and line storage, registered read
    always_ff @(posedge clk) begin
        if (i_we) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            line_mem[i_wr_index] <= i_wr_line;
        end
        rd_tag_q <= bypass ? i_wr_tag : tag_mem[i_rd_index];
        o_line   <= bypass ? i_wr_line : line_mem[i_rd_index];
    end

    assign o_tagv = '{valid: rd_valid_q, tag: rd_tag_q};

endmodule

`default_nettype wire

// ==== icache_top.f ====
hdl/icache_pkg.sv
hdl/icache_way.sv
hdl/icache_refill.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
sim/icache_sva.sv
sim/tb_icache_mem.sv
sim/tb_icache.sv

// ==== sim/icache_sva.sv ====
`default_nettype none

module icache_sva (
    input wire logic        clk,
    input wire logic        rstn,
    input wire logic        i_req_valid,
    input wire logic        i_req_ready,
    input wire logic        i_resp_valid,
    input wire logic        i_mem_valid,
    input wire logic [31:0] i_mem_addr,
    input wire logic        i_mem_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    int         fail_count = 0;
    logic [3:0] open_cnt;       // accepted fetches not yet answered
    logic       accept;

    assign accept = i_req_valid && i_req_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            open_cnt <= '0;
        end else begin
            open_cnt <= open_cnt + 4'(accept) - 4'(i_resp_valid);
        end
    end

    // memory request stays up with the same address until taken
    mem_hold: assert property (@(posedge clk) disable iff (!rstn)
        i_mem_valid && !i_mem_ready |=> i_mem_valid && $stable(i_mem_addr))
        else begin
            $error("memory request dropped or changed before ready");
            fail_count++;
        end

    resp_after_req: assert property (@(posedge clk) disable iff (!rstn)
        i_resp_valid |-> open_cnt != 0)
        else begin
            $error("response without an accepted fetch");
            fail_count++;
        end

    // a fetch not answered on the next cycle has to go to memory
    hit_latency: assert property (@(posedge clk) disable iff (!rstn)
        accept ##1 !i_resp_valid |=> i_mem_valid)
        else begin
            $error("fetch without a memory request not answered one cycle after acceptance");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== sim/tb_icache.sv ====
`default_nettype none

module tb_icache
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_DIRECTED      = 16;
    localparam int N_RANDOM        = 200;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 20 + 200;

    typedef struct packed {
        logic [31:0]        pc;
        logic [FETCH_W-1:0] data;
        exc_t               exc;
        logic               miss;
        logic [31:0]        cycle;  // acceptance cycle
    } expect_t;

    logic              clk;
    logic              rstn;
    logic              req_valid;
    fetch_req_t        req;
    logic              req_ready;
    logic              resp_valid;
    fetch_resp_t       resp;
    logic              mem_valid;
    logic [31:0]       mem_addr;
    logic              mem_ready;
    logic [LINE_W-1:0] mem_line;

    expect_t           exp_q [$];
    logic [31:0]       cycle_cnt;
    int                fires_seen;  // memory transfers since the last response
    integer            seed;

    // reference copy of tags, valid and lru bits
    logic              model_valid [SET_NUM][WAY_NUM];
    logic [TAG_W-1:0]  model_tag   [SET_NUM][WAY_NUM];
    logic              model_lru   [SET_NUM];

    icache_top u_dut (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (req_valid),
        .i_req        (req),
        .o_req_ready  (req_ready),
        .o_resp_valid (resp_valid),
        .o_resp       (resp),
        .o_mem_valid  (mem_valid),
        .o_mem_addr   (mem_addr),
        .i_mem_ready  (mem_ready),
        .i_mem_line   (mem_line)
    );

    tb_icache_mem u_mem (
        .clk         (clk),
        .rstn        (rstn),
        .i_mem_valid (mem_valid),
        .i_mem_addr  (mem_addr),
        .o_mem_ready (mem_ready),
        .o_mem_line  (mem_line)
    );

    bind icache_top icache_sva u_sva (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (i_req_valid),
        .i_req_ready  (o_req_ready),
        .i_resp_valid (o_resp_valid),
        .i_mem_valid  (o_mem_valid),
        .i_mem_addr   (o_mem_addr),
        .i_mem_ready  (i_mem_ready)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic logic [31:0] make_addr(input logic [TAG_W-1:0] tag,
                                              input logic [INDEX_W-1:0] index,
                                              input logic [OFFSET_W-1:0] offset);
        return {tag, index, offset};
    endfunction

    // pair at the 8-byte chunk that holds addr
    function automatic logic [FETCH_W-1:0] expected_pair(input logic [31:0] addr);
        logic [31:0] chunk_addr;
        chunk_addr = {addr[31:3], 3'b000};
        return {chunk_addr, ~chunk_addr};
    endfunction

    // 1 on a miss; applies the replacement rule to the model
    function automatic logic access_model(input logic [31:0] addr);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        logic               way;
        idx = addr[OFFSET_W +: INDEX_W];
        tag = addr[OFFSET_W + INDEX_W +: TAG_W];
        for (int w = 0; w < WAY_NUM; w++) begin
            if (model_valid[idx][w] && model_tag[idx][w] == tag) begin
                model_lru[idx] = (w == 0);  // other way goes next
                return 1'b0;
            end
        end
        way                   = model_lru[idx];
        model_valid[idx][way] = 1'b1;
        model_tag[idx][way]   = tag;
        model_lru[idx]        = ~way;
        return 1'b1;
    endfunction

    // want_miss below 0 leaves the outcome to the model alone
    task automatic send_fetch(input logic [31:0] addr, input int want_miss);
        expect_t exp;
        req_valid = 1'b1;
        req.addr  = addr;
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        exp.pc    = addr;
        exp.cycle = cycle_cnt;
        if (addr[1:0] != 2'b00) begin
            exp.data = {INST_NOP, INST_NOP};
            exp.exc  = EXC_ADEF;
            exp.miss = 1'b0;
        end else begin
            exp.data = expected_pair(addr);
            exp.exc  = EXC_NONE;
            exp.miss = access_model(addr);
        end
        if (want_miss >= 0) begin
            assert (exp.miss == want_miss[0])
                else report_error($sformatf("model outcome for %h not the intended one", addr));
        end
        exp_q.push_back(exp);
        @(posedge clk);     // request taken on this edge
        #1;
        req_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        expect_t exp;
        if (rstn && mem_valid && mem_ready) begin
            assert (exp_q.size() != 0) else report_error("memory request with no fetch pending");
            assert (exp_q[0].miss)
                else report_error($sformatf("memory request for hit pc %h", exp_q[0].pc));
            assert (mem_addr == {exp_q[0].pc[31:OFFSET_W], {OFFSET_W{1'b0}}})
                else report_error($sformatf("memory address %h for pc %h", mem_addr, exp_q[0].pc));
            fires_seen++;
        end
        if (rstn && resp_valid) begin
            assert (exp_q.size() != 0) else report_error("response with no fetch pending");
            exp = exp_q.pop_front();
            assert (resp.pc == exp.pc)
                else report_error($sformatf("pc got %h expected %h", resp.pc, exp.pc));
            assert (resp.data == exp.data)
                else report_error($sformatf("pc %h data got %h expected %h",
                                            exp.pc, resp.data, exp.data));
            assert (resp.exc == exp.exc)
                else report_error($sformatf("pc %h exc got %h expected %h",
                                            exp.pc, resp.exc, exp.exc));
            assert (fires_seen == int'(exp.miss))
                else report_error($sformatf("pc %h saw %0d memory requests, expected %0d",
                                            exp.pc, fires_seen, exp.miss));
            if (!exp.miss) begin
                assert (cycle_cnt == exp.cycle + 1)
                    else report_error($sformatf("pc %h answered %0d cycles after acceptance",
                                                exp.pc, cycle_cnt - exp.cycle));
            end
            fires_seen = 0;
        end
    end

    always @(u_dut.u_sva.fail_count) begin
        if (u_dut.u_sva.fail_count != 0) begin
            report_error("a bound protocol assertion failed");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error at %0t ns: simulation timed out with responses missing", $time);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0]         r;
        logic [OFFSET_W-1:0] offset;
        seed       = 32'h30b0f233;
        clk        = 1'b0;
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        cycle_cnt  = '0;
        fires_seen = 0;
        for (int s = 0; s < SET_NUM; s++) begin
            model_lru[s] = 1'b0;
            for (int w = 0; w < WAY_NUM; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        assert (!resp_valid && !mem_valid && req_ready)
            else report_error("outputs not idle after reset");

        // first fetch misses, rest of the line hits back to back
        send_fetch(make_addr(20'h12345, 6'd5, 6'h10), 1);
        send_fetch(make_addr(20'h12345, 6'd5, 6'h18), 0);
        send_fetch(make_addr(20'h12345, 6'd5, 6'h00), 0);
        send_fetch(make_addr(20'h12345, 6'd5, 6'h38), 0);
        send_fetch(make_addr(20'h12345, 6'd5, 6'h3c), 0);
        wait_cycles(3);
        send_fetch(make_addr(20'h12345, 6'd5, 6'h08), 0);
        wait_cycles(2);

        // A, B, A, C at one set: C takes B's way
        send_fetch(make_addr(20'h00aaa, 6'd9, 6'h00), 1);
        send_fetch(make_addr(20'h00bbb, 6'd9, 6'h00), 1);
        send_fetch(make_addr(20'h00aaa, 6'd9, 6'h20), 0);
        send_fetch(make_addr(20'h00ccc, 6'd9, 6'h04), 1);
        send_fetch(make_addr(20'h00aaa, 6'd9, 6'h28), 0);
        send_fetch(make_addr(20'h00bbb, 6'd9, 6'h30), 1);
        wait_cycles(2);

        // misaligned fetches, one of them to an uncached line
        send_fetch(make_addr(20'h12345, 6'd5, 6'h22), 0);
        send_fetch(make_addr(20'h12345, 6'd5, 6'h05), 0);
        send_fetch(make_addr(20'h12345, 6'd5, 6'h00), 0);
        send_fetch(make_addr(20'h77777, 6'd40, 6'h01), 0);

        // four tags over four sets
        for (int n = 0; n < N_RANDOM; n++) begin
            r      = $random(seed);
            offset = r[9:4];
            if (r[15:12] != 4'h0) begin
                offset[1:0] = 2'b00;    // mostly aligned
            end
            send_fetch(make_addr(20'h00100 + 20'(r[1:0]), 6'd16 + 6'(r[3:2]), offset), -1);
            if (r[17:16] == 2'b00) begin
                wait_cycles(int'(r[19:18]));
            end
        end

        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        wait_cycles(4);
        if (u_dut.u_sva.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_icache_mem.sv ====
`default_nettype none

module tb_icache_mem
    import icache_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              i_mem_valid,
    input  wire logic [31:0]       i_mem_addr,
    output logic                   o_mem_ready,
    output logic [LINE_W-1:0]      o_mem_line
);

    timeunit 1ns;
    timeprecision 100ps;

    integer seed;
    int     delay;

    // each 64-bit chunk holds its own address over the inverse of it
    function automatic logic [LINE_W-1:0] line_data(input logic [31:0] line_addr);
        logic [LINE_W-1:0] line;
        logic [31:0]       chunk_addr;
        line = '0;
        for (int c = 0; c < LINE_W / 64; c++) begin
            chunk_addr       = line_addr + 32'(8 * c);
            line[c*64 +: 64] = {chunk_addr, ~chunk_addr};
        end
        return line;
    endfunction

    initial begin
        seed        = 32'h30b0f233;
        o_mem_ready = 1'b0;
        o_mem_line  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rstn && i_mem_valid) begin
                delay = 1 + int'($unsigned($random(seed)) % 4);   // 1 to 4 cycles
                repeat (delay) @(posedge clk);
                #1;
                o_mem_line  = line_data(i_mem_addr);
                o_mem_ready = 1'b1;     // line comes with ready
                @(posedge clk);
                #1;
                o_mem_ready = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire
